/* filelist.f */
+incdir+hw
hw/hangmanGamePkg.sv
hw/hangmanResultPkg.sv
hw/wordLoader.sv
hw/letterScanner.sv
hw/tallyCounter.sv
hw/gameController.sv
hw/hangmanTop.sv
sim/hangmanTb.sv

/* run.sh */
#!/bin/sh
# compile the hangman testbench with Verilator and run it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module hangmanTb \
    -f filelist.f -o hangmanSim || { echo "build failed"; exit 1; }

result=$(./obj_dir/hangmanSim)
echo "$result"
echo "$result" | grep -q "^=== PASS ===$" && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* sim/hangmanTb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "hangman_config.svh"

module hangmanTb;

    logic                         clk = 1'b0;
    logic                         nRst;
    logic                         keyStrobe;
    hangmanGamePkg::letterT       keyCode;
    logic                         start;
    logic                         gameEnd;
    hangmanGamePkg::letterT       guess;
    hangmanGamePkg::letterT       letter;
    logic [`HANGMAN_WORD_LEN-1:0] foundMask;
    hangmanResultPkg::tallyT      correct;
    hangmanResultPkg::tallyT      incorrect;
    logic                         mistake;
    logic                         busy;
    logic                         gameRdy;
    logic                         red;
    logic                         green;

    logic [31:0] rngState = 32'h2bcc;
    int          errorCount = 0;
    int          failCount = 0;

    hangmanGamePkg::letterT       modelWord [`HANGMAN_WORD_LEN];
    logic [`HANGMAN_WORD_LEN-1:0] modelMask;
    int                           modelKeys;
    int                           modelCorrect;
    int                           modelIncorrect;
    hangmanGamePkg::letterT       modelLast; // last accepted guess.

    hangmanTop u_dut (
        .clk       (clk),
        .nRst      (nRst),
        .keyStrobe (keyStrobe),
        .keyCode   (keyCode),
        .start     (start),
        .gameEnd   (gameEnd),
        .guess     (guess),
        .letter    (letter),
        .foundMask (foundMask),
        .correct   (correct),
        .incorrect (incorrect),
        .mistake   (mistake),
        .busy      (busy),
        .gameRdy   (gameRdy),
        .red       (red),
        .green     (green)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] nextRandom();
        rngState = rngState * 32'd1664525 + 32'd1013904223;
        return rngState;
    endfunction

    // small span from 'A' keeps hits and repeats common.
    function automatic hangmanGamePkg::letterT pickLetter(input int span);
        logic [31:0] r;
        r = nextRandom();
        return hangmanGamePkg::letterT'(32'h41 + (r >> 16) % span);
    endfunction

    function automatic bit gameFinished();
        return (modelCorrect >= `HANGMAN_WORD_LEN)
            || (modelIncorrect >= `HANGMAN_MAX_MISTAKES);
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else begin
            errorCount++;
            $display("error: %s is 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic clearModel();
        modelMask      = '0;
        modelKeys      = 0;
        modelCorrect   = 0;
        modelIncorrect = 0;
        modelLast      = '0;
    endtask

    task automatic enterKey(input hangmanGamePkg::letterT k);
        keyCode   = k;
        keyStrobe = 1'b1;
        @(negedge clk);
        keyStrobe = 1'b0;
        if (modelKeys < `HANGMAN_WORD_LEN) begin
            modelWord[modelKeys] = k;
            modelKeys++;
        end
    endtask

    task automatic pressStart();
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic waitGameReady();
        int cycles;
        cycles = 0;
        while (!gameRdy && cycles < 10) begin
            @(negedge clk);
            cycles++;
        end
        assert (gameRdy) else begin
            failCount++;
            $display("timeout: the game never became ready after start");
        end
    endtask

    task automatic loadWord(input bit earlyStart);
        if (earlyStart) begin
            repeat (3) enterKey(pickLetter(5));
            pressStart(); // word not full yet.
            checkValue("gameRdy", 32'(gameRdy), 32'd0);
            repeat (2) enterKey(pickLetter(5));
            enterKey(pickLetter(5)); // sixth key is dropped.
        end else begin
            repeat (5) enterKey(pickLetter(5));
        end
        pressStart();
        waitGameReady();
    endtask

    task automatic submitGuess(input hangmanGamePkg::letterT g);
        logic expAccept;
        int   newHits;
        int   pulses;
        int   cycles;
        expAccept = (g != '0) && (g != modelLast) && !gameFinished();
        newHits   = 0;
        pulses    = 0;
        cycles    = 0;
        guess     = g;
        @(negedge clk);
        guess = '0;
        checkValue("busy", 32'(busy), 32'(expAccept));
        if (expAccept) begin
            modelLast = g;
            for (int i = 0; i < `HANGMAN_WORD_LEN; i++) begin
                if (modelWord[i] == g && !modelMask[i]) begin
                    modelMask[i] = 1'b1;
                    newHits++;
                end
            end
            if (newHits > 0) begin
                modelCorrect = modelCorrect + newHits;
                if (modelCorrect > `HANGMAN_WORD_LEN) begin
                    modelCorrect = `HANGMAN_WORD_LEN;
                end
            end else if (modelIncorrect < `HANGMAN_MAX_MISTAKES) begin
                modelIncorrect++; // repeats of found letters land here too.
            end
            while (busy && cycles < 20) begin
                if (mistake) begin
                    pulses++;
                end
                @(negedge clk);
                cycles++;
            end
            assert (!busy) else begin
                failCount++;
                $display("timeout: busy stayed high after an accepted guess");
            end
            checkValue("mistake", 32'(pulses), 32'(newHits == 0));
        end else begin
            // a dropped guess starts no scan and no score.
            repeat (7) begin
                @(negedge clk);
                checkValue("busy", 32'(busy), 32'd0);
                checkValue("mistake", 32'(mistake), 32'd0);
            end
        end
        checkValue("gameRdy", 32'(gameRdy), 32'd1);
        checkValue("letter", 32'(letter), 32'(modelLast));
        checkValue("foundMask", 32'(foundMask), 32'(modelMask));
        checkValue("correct", 32'(correct), 32'(modelCorrect));
        checkValue("incorrect", 32'(incorrect), 32'(modelIncorrect));
        @(negedge clk); // lamps trail the tally.
        checkValue("green", 32'(green), 32'(modelCorrect >= `HANGMAN_WORD_LEN));
        checkValue("red", 32'(red), 32'(modelIncorrect >= `HANGMAN_MAX_MISTAKES));
    endtask

    task automatic playGame(input bit firstGame);
        int guesses;
        guesses = 0;
        loadWord(firstGame);
        while (!gameFinished() && guesses < 60) begin
            submitGuess(pickLetter(7));
            if (firstGame && guesses == 0) begin
                submitGuess(modelLast); // same letter again.
            end
            guesses++;
        end
        assert (gameFinished()) else begin
            failCount++;
            $display("failure: the game was still open after 60 guesses");
        end
        repeat (3) submitGuess(pickLetter(7));
    endtask

    task automatic endGame();
        gameEnd = 1'b1;
        @(negedge clk);
        gameEnd = 1'b0;
        clearModel();
        checkValue("gameRdy", 32'(gameRdy), 32'd0);
        checkValue("correct", 32'(correct), 32'd0);
        checkValue("incorrect", 32'(incorrect), 32'd0);
        checkValue("foundMask", 32'(foundMask), 32'd0);
        checkValue("letter", 32'(letter), 32'd0);
        @(negedge clk);
        checkValue("red", 32'(red), 32'd0);
        checkValue("green", 32'(green), 32'd0);
    endtask

    initial begin
        nRst      = 1'b0;
        keyStrobe = 1'b0;
        keyCode   = '0;
        start     = 1'b0;
        gameEnd   = 1'b0;
        guess     = '0;
        clearModel();
        repeat (2) @(negedge clk);
        nRst = 1'b1;
        checkValue("busy", 32'(busy), 32'd0);
        checkValue("gameRdy", 32'(gameRdy), 32'd0);
        checkValue("mistake", 32'(mistake), 32'd0);
        checkValue("red", 32'(red), 32'd0);
        checkValue("green", 32'(green), 32'd0);
        checkValue("correct", 32'(correct), 32'd0);
        checkValue("incorrect", 32'(incorrect), 32'd0);
        checkValue("foundMask", 32'(foundMask), 32'd0);
        for (int game = 0; game < 3; game++) begin
            playGame(game == 0);
            endGame();
        end
        $display("errors: %0d value mismatches, %0d other failures", errorCount, failCount);
        if (errorCount == 0 && failCount == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hw/hangmanTop.sv */
`timescale 1ns/10ps
`default_nettype none

`include "hangman_config.svh"

module hangmanTop (
    input  logic                            clk,
    input  logic                            nRst,
    input  logic                            keyStrobe,
    input  hangmanGamePkg::letterT          keyCode,
    input  logic                            start,
    input  logic                            gameEnd,
    input  hangmanGamePkg::letterT          guess,
    output hangmanGamePkg::letterT          letter,
    output logic [`HANGMAN_WORD_LEN-1:0]    foundMask,
    output hangmanResultPkg::tallyT         correct,
    output hangmanResultPkg::tallyT         incorrect,
    output logic                            mistake,
    output logic                            busy,
    output logic                            gameRdy,
    output logic                            red,
    output logic                            green
);
    hangmanGamePkg::letterT [`HANGMAN_WORD_LEN-1:0] word;
    hangmanResultPkg::tallyT                        hits;
    hangmanResultPkg::outcomeT                      outcome;

    logic wordFull;
    logic loadEnable;
    logic clearGame;
    logic scanStart;
    logic scanDone;
    logic scoreStrobe;

    wordLoader u_wordLoader (
        .clk        (clk),
        .nRst       (nRst),
        .clearGame  (clearGame),
        .loadEnable (loadEnable),
        .keyStrobe  (keyStrobe),
        .keyCode    (keyCode),
        .word       (word),
        .wordFull   (wordFull)
    );

    letterScanner u_letterScanner (
        .clk        (clk),
        .nRst       (nRst),
        .clearGame  (clearGame),
        .scanStart  (scanStart),
        .letter     (letter),
        .word       (word),
        .foundMask  (foundMask),
        .hits       (hits),
        .scanDone   (scanDone)
    );

    tallyCounter u_tallyCounter (
        .clk         (clk),
        .nRst        (nRst),
        .clearGame   (clearGame),
        .scoreStrobe (scoreStrobe),
        .hits        (hits),
        .correct     (correct),
        .incorrect   (incorrect),
        .outcome     (outcome)
    );

    gameController u_gameController (
        .clk         (clk),
        .nRst        (nRst),
        .start       (start),
        .gameEnd     (gameEnd),
        .guess       (guess),
        .wordFull    (wordFull),
        .scanDone    (scanDone),
        .hits        (hits),
        .outcome     (outcome),
        .loadEnable  (loadEnable),
        .clearGame   (clearGame),
        .scanStart   (scanStart),
        .scoreStrobe (scoreStrobe),
        .mistake     (mistake),
        .busy        (busy),
        .gameRdy     (gameRdy),
        .red         (red),
        .green       (green),
        .letter      (letter)
    );

endmodule

`default_nettype wire

/* hw/gameController.sv */
`timescale 1ns/10ps
`default_nettype none

module gameController (
    input  logic                        clk,
    input  logic                        nRst,
    input  logic                        start,
    input  logic                        gameEnd,
    input  hangmanGamePkg::letterT      guess,
    input  logic                        wordFull,
    input  logic                        scanDone,
    input  hangmanResultPkg::tallyT     hits,
    input  hangmanResultPkg::outcomeT   outcome,
    output logic                        loadEnable,
    output logic                        clearGame,
    output logic                        scanStart,
    output logic                        scoreStrobe,
    output logic                        mistake,
    output logic                        busy,
    output logic                        gameRdy,
    output logic                        red,
    output logic                        green,
    output hangmanGamePkg::letterT      letter
);
    hangmanGamePkg::gameStateT state;
    hangmanGamePkg::gameStateT nextState;

    logic inWait;
    logic accept;

    assign inWait = (state == hangmanGamePkg::WAIT_GUESS);

    // end request wins over a guess in the same cycle.
    assign accept = inWait && !gameEnd
                    && (outcome == hangmanResultPkg::PLAYING)
                    && (guess != '0)
                    && (guess != letter); // same key held is not a new guess.

    assign loadEnable  = (state == hangmanGamePkg::WORD_ENTRY);
    assign clearGame   = inWait && gameEnd;
    assign scanStart   = accept;
    assign scoreStrobe = (state == hangmanGamePkg::SCORE);
    assign mistake     = scoreStrobe && (hits == '0);
    assign busy        = (state == hangmanGamePkg::SCAN) || scoreStrobe;
    assign gameRdy     = inWait || scoreStrobe;

    always_comb begin
        nextState = state;
        case (state)
            hangmanGamePkg::WORD_ENTRY: begin
                if (start && wordFull) begin
                    nextState = hangmanGamePkg::WAIT_GUESS;
                end
            end
            hangmanGamePkg::WAIT_GUESS: begin
                if (gameEnd) begin
                    nextState = hangmanGamePkg::WORD_ENTRY;
                end else if (accept) begin
                    nextState = hangmanGamePkg::SCAN;
                end
            end
            hangmanGamePkg::SCAN: begin
                if (scanDone) begin
                    nextState = hangmanGamePkg::SCORE;
                end
            end
            hangmanGamePkg::SCORE: begin
                nextState = hangmanGamePkg::WAIT_GUESS; // tally lands here.
            end
            default: begin
                nextState = hangmanGamePkg::WORD_ENTRY;
            end
        endcase
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            state <= hangmanGamePkg::WORD_ENTRY;
        end else begin
            state <= nextState;
        end
    end

    // last accepted letter also drives the scanner compare.
    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            letter <= '0;
        end else if (clearGame) begin
            letter <= '0;
        end else if (accept) begin
            letter <= guess;
        end
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            red   <= 1'b0;
            green <= 1'b0;
        end else begin
            red   <= (outcome == hangmanResultPkg::LOST);
            green <= (outcome == hangmanResultPkg::WON); // one cycle behind the tally.
        end
    end

    assert property (@(posedge clk) disable iff (!nRst)
        scanDone |-> state == hangmanGamePkg::SCAN)
    else $error("gameController: scanDone seen in state 0x%0h", state);

endmodule

`default_nettype wire

/* hw/tallyCounter.sv */
`timescale 1ns/10ps
`default_nettype none

`include "hangman_config.svh"

module tallyCounter (
    input  logic                        clk,
    input  logic                        nRst,
    input  logic                        clearGame,
    input  logic                        scoreStrobe,
    input  hangmanResultPkg::tallyT     hits,
    output hangmanResultPkg::tallyT     correct,
    output hangmanResultPkg::tallyT     incorrect,
    output hangmanResultPkg::outcomeT   outcome
);
    localparam hangmanResultPkg::tallyT WinCount =
        hangmanResultPkg::tallyT'(`HANGMAN_WORD_LEN);
    localparam hangmanResultPkg::tallyT LoseCount =
        hangmanResultPkg::tallyT'(`HANGMAN_MAX_MISTAKES);

    logic [3:0] correctSum; // one bit wider than a tally.
    logic       playing;

    assign correctSum = {1'b0, correct} + {1'b0, hits};
    assign playing    = (outcome == hangmanResultPkg::PLAYING);

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            correct   <= '0;
            incorrect <= '0;
        end else if (clearGame) begin
            correct   <= '0;
            incorrect <= '0;
        end else if (scoreStrobe && playing) begin
            if (hits != '0) begin
                if (correctSum >= 4'(WinCount)) begin
                    correct <= WinCount;
                end else begin
                    correct <= correctSum[2:0];
                end
            end else if (incorrect < LoseCount) begin
                incorrect <= incorrect + 1'b1; // nothing new found.
            end
        end
    end

    // a win takes precedence.
    always_comb begin
        if (correct >= WinCount) begin
            outcome = hangmanResultPkg::WON;
        end else if (incorrect >= LoseCount) begin
            outcome = hangmanResultPkg::LOST;
        end else begin
            outcome = hangmanResultPkg::PLAYING;
        end
    end

    assert property (@(posedge clk) disable iff (!nRst)
        correct <= WinCount)
    else $error("tallyCounter: correct 0x%0h above word length", correct);

endmodule

`default_nettype wire

/* hw/letterScanner.sv */
`timescale 1ns/10ps
`default_nettype none

`include "hangman_config.svh"

module letterScanner (
    input  logic                                             clk,
    input  logic                                             nRst,
    input  logic                                             clearGame,
    input  logic                                             scanStart,
    input  hangmanGamePkg::letterT                           letter,
    input  hangmanGamePkg::letterT [`HANGMAN_WORD_LEN-1:0]   word,
    output logic [`HANGMAN_WORD_LEN-1:0]                     foundMask,
    output hangmanResultPkg::tallyT                          hits,
    output logic                                             scanDone
);
    localparam int PosW = $clog2(`HANGMAN_WORD_LEN);

    logic [PosW-1:0] pos;
    logic            active;
    logic            lastPos;
    logic            newHit;

    assign lastPos = (pos == PosW'(`HANGMAN_WORD_LEN - 1));
    // same position for the compare and the found check.
    assign newHit  = (word[pos] == letter) && !foundMask[pos];

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            pos       <= '0;
            active    <= 1'b0;
            scanDone  <= 1'b0;
            hits      <= '0;
            foundMask <= '0;
        end else if (clearGame) begin
            pos       <= '0;
            active    <= 1'b0;
            scanDone  <= 1'b0;
            hits      <= '0;
            foundMask <= '0;
        end else begin
            scanDone <= 1'b0;
            if (scanStart) begin
                pos    <= '0;
                active <= 1'b1;
                hits   <= '0; // hits belong to one scan.
            end else if (active) begin
                if (newHit) begin
                    foundMask[pos] <= 1'b1;
                    hits           <= hits + 1'b1;
                end
                if (lastPos) begin
                    active   <= 1'b0;
                    scanDone <= 1'b1; // fifth step.
                end else begin
                    pos <= pos + 1'b1;
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (!nRst)
        scanStart |-> !active)
    else $error("letterScanner: scanStart at position 0x%0h", pos);

    // mask five edges back is the mask the scan started from.
    assert property (@(posedge clk) disable iff (!nRst || clearGame)
        scanDone |-> hits <= $countones(foundMask ^ $past(foundMask, 5)))
    else $error("letterScanner: hits 0x%0h above new mask bits", hits);

endmodule

`default_nettype wire

/* hw/wordLoader.sv */
`timescale 1ns/10ps
`default_nettype none

`include "hangman_config.svh"

module wordLoader (
    input  logic                                             clk,
    input  logic                                             nRst,
    input  logic                                             clearGame,
    input  logic                                             loadEnable,
    input  logic                                             keyStrobe,
    input  hangmanGamePkg::letterT                           keyCode,
    output hangmanGamePkg::letterT [`HANGMAN_WORD_LEN-1:0]   word,
    output logic                                             wordFull
);
    localparam int CountW = $clog2(`HANGMAN_WORD_LEN + 1);

    logic [CountW-1:0] count;
    logic              takeKey;

    assign wordFull = (count == CountW'(`HANGMAN_WORD_LEN));
    assign takeKey  = loadEnable && keyStrobe && !wordFull; // extra keys dropped.

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            count <= '0;
        end else if (clearGame) begin
            count <= '0;
        end else if (takeKey) begin
            count <= count + 1'b1;
        end
    end

    // new key enters at the top so the first letter ends at position 0.
    always_ff @(posedge clk) begin
        if (takeKey) begin
            word <= {keyCode, word[`HANGMAN_WORD_LEN-1:1]};
        end
    end

    assert property (@(posedge clk) disable iff (!nRst)
        count <= CountW'(`HANGMAN_WORD_LEN))
    else $error("wordLoader: letter count 0x%0h past word length", count);

endmodule

`default_nettype wire

/* hw/hangmanResultPkg.sv */
`default_nettype none

package hangmanResultPkg;

    // wide enough for six mistakes.
    typedef logic [2:0] tallyT;

    typedef enum logic [1:0] {
        PLAYING = 2'd0,
        WON     = 2'd1,
        LOST    = 2'd2
    } outcomeT;

endpackage

`default_nettype wire

/* hw/hangmanGamePkg.sv */
`default_nettype none

`include "hangman_config.svh"

package hangmanGamePkg;

    // one key code, zero means no key.
    typedef logic [`HANGMAN_LETTER_W-1:0] letterT;

    typedef enum logic [2:0] {
        WORD_ENTRY = 3'd0, // host keys in the word.
        WAIT_GUESS = 3'd1,
        SCAN       = 3'd2, // walking the positions.
        SCORE      = 3'd3
    } gameStateT;

endpackage

`default_nettype wire

/* hw/hangman_config.svh */
`ifndef HANGMAN_CONFIG_SVH
`define HANGMAN_CONFIG_SVH

// bits in one key or letter code.
`define HANGMAN_LETTER_W 8

// letters in the secret word.
`define HANGMAN_WORD_LEN 5

// mistakes that end the game as a loss.
`define HANGMAN_MAX_MISTAKES 6

`endif
